//--- verilog/versat_pkg.sv
package versat_pkg;

   // bus and datapath widths
   parameter int AXI_ADDR_W = 32;
   parameter int DATA_W = 32;
   parameter int LEN_W = 8;

   // reduction opcode, code 3 falls back to sum
   typedef enum logic [1:0] {
      OP_SUM = 2'd0,
      OP_XOR = 2'd1,
      OP_MAX = 2'd2
   } opcode_e;

   typedef enum logic [0:0] {
      ST_IDLE = 1'b0,
      ST_READ = 1'b1
   } unit_state_e;

   // per-unit configuration
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [LEN_W-1:0] len;
      opcode_e op;
   } unit_cfg_t;

   // data bus request, held until the last beat
   typedef struct packed {
      logic valid;
      logic [AXI_ADDR_W-1:0] addr;
      logic [LEN_W-1:0] len;
   } db_req_t;

   // data bus response, one word per ready cycle
   typedef struct packed {
      logic ready;
      logic last;
      logic [DATA_W-1:0] rdata;
   } db_rsp_t;

endpackage

//--- verilog/versat_csr.sv
`timescale 1ns/10ps

module versat_csr #(
   parameter int N_UNITS = 2,
   parameter int ADDR_W = 26
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [versat_pkg::DATA_W-1:0] iob_wdata_i,
   input  logic [3:0] iob_wstrb_i,
   output logic iob_rvalid_o,
   output logic [versat_pkg::DATA_W-1:0] iob_rdata_o,
   output versat_pkg::unit_cfg_t [N_UNITS-1:0] cfg_o,
   output logic [N_UNITS-1:0] start_o,
   input  logic [N_UNITS-1:0] busy_i,
   input  logic [N_UNITS-1:0] done_i,
   input  logic [N_UNITS-1:0][versat_pkg::DATA_W-1:0] result_i
);

   localparam int UNIT_W = ADDR_W - 5;

   // register offsets inside one unit window
   localparam logic [2:0] REG_ADDR = 3'd0;
   localparam logic [2:0] REG_LEN = 3'd1;
   localparam logic [2:0] REG_OP = 3'd2;
   localparam logic [2:0] REG_CTRL = 3'd3;
   localparam logic [2:0] REG_RESULT = 3'd4;

   logic [UNIT_W-1:0] unit_idx;
   logic [2:0] reg_idx;
   logic wr_en;
   logic rd_en;
   logic [versat_pkg::DATA_W-1:0] rd_data;
   logic [versat_pkg::DATA_W-1:0] rdata_q;
   logic rvalid_q;
   logic [N_UNITS-1:0] start_q;
   versat_pkg::unit_cfg_t [N_UNITS-1:0] cfg_q;

   // byte address to word index, 8 words per unit
   assign unit_idx = iob_addr_i[ADDR_W-1:5];
   assign reg_idx = iob_addr_i[4:2];

   // any strobe bit makes a full-word write
   assign wr_en = iob_avalid_i && (iob_wstrb_i != 4'b0000);
   assign rd_en = iob_avalid_i && (iob_wstrb_i == 4'b0000);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cfg_q <= '0;
         start_q <= '0;
      end else begin
         start_q <= '0;
         for (int u = 0; u < N_UNITS; u++) begin
            if (wr_en && unit_idx == UNIT_W'(u)) begin
               case (reg_idx)
                  REG_ADDR: cfg_q[u].addr <= iob_wdata_i[versat_pkg::AXI_ADDR_W-1:0];
                  REG_LEN: cfg_q[u].len <= iob_wdata_i[versat_pkg::LEN_W-1:0];
                  REG_OP: cfg_q[u].op <= versat_pkg::opcode_e'(iob_wdata_i[1:0]);
                  // busy units drop the pulse themselves
                  REG_CTRL: start_q[u] <= iob_wdata_i[0];
                  default: ;
               endcase
            end
         end
      end
   end

   // readback mux, out of range units read zero
   always_comb begin
      rd_data = '0;
      for (int u = 0; u < N_UNITS; u++) begin
         if (unit_idx == UNIT_W'(u)) begin
            case (reg_idx)
               REG_ADDR: rd_data = versat_pkg::DATA_W'(cfg_q[u].addr);
               REG_LEN: rd_data = versat_pkg::DATA_W'(cfg_q[u].len);
               REG_OP: rd_data = versat_pkg::DATA_W'(cfg_q[u].op);
               REG_CTRL: rd_data = {{(versat_pkg::DATA_W-2){1'b0}}, done_i[u], busy_i[u]};
               REG_RESULT: rd_data = result_i[u];
               default: rd_data = '0;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rd_data;
      end
   end

   assign iob_rvalid_o = rvalid_q;
   assign iob_rdata_o = rdata_q;
   assign cfg_o = cfg_q;
   assign start_o = start_q;

   // rvalid answers exactly one read of the previous cycle
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_rvalid_o |-> $past(rd_en));

   // a start pulse comes from one write and hits one unit
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      |start_o |-> $onehot(start_o) && $past(wr_en));

endmodule

//--- verilog/versat_vunit.sv
`timescale 1ns/10ps

module versat_vunit (
   input  logic clk_i,
   input  logic rst_n_i,
   input  versat_pkg::unit_cfg_t cfg_i,
   input  logic start_i,
   output versat_pkg::db_req_t req_o,
   input  versat_pkg::db_rsp_t rsp_i,
   output logic busy_o,
   output logic done_o,
   output logic [versat_pkg::DATA_W-1:0] result_o
);

   versat_pkg::unit_state_e state_q;
   versat_pkg::unit_cfg_t cfg_q;
   logic [versat_pkg::DATA_W-1:0] acc_q;
   logic [versat_pkg::DATA_W-1:0] result_q;
   logic [versat_pkg::DATA_W-1:0] folded;
   logic done_q;
   logic take_start;
   logic last_beat;

   // one reduction step, zero is the identity of all three
   function automatic logic [versat_pkg::DATA_W-1:0] fold(
      input versat_pkg::opcode_e op,
      input logic [versat_pkg::DATA_W-1:0] acc,
      input logic [versat_pkg::DATA_W-1:0] word
   );
      case (op)
         versat_pkg::OP_XOR: fold = acc ^ word;
         versat_pkg::OP_MAX: fold = (word > acc) ? word : acc;
         default: fold = acc + word;
      endcase
   endfunction

   // starts while busy are dropped here
   assign take_start = (state_q == versat_pkg::ST_IDLE) && start_i;
   assign last_beat = rsp_i.ready && rsp_i.last;
   assign folded = fold(cfg_q.op, acc_q, rsp_i.rdata);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= versat_pkg::ST_IDLE;
         done_q <= 1'b0;
         result_q <= '0;
      end else begin
         case (state_q)
            versat_pkg::ST_IDLE: begin
               if (start_i) begin
                  // empty burst finishes at once with a zero result
                  if (cfg_i.len == '0) begin
                     done_q <= 1'b1;
                     result_q <= '0;
                  end else begin
                     done_q <= 1'b0;
                     state_q <= versat_pkg::ST_READ;
                  end
               end
            end
            versat_pkg::ST_READ: begin
               if (last_beat) begin
                  result_q <= folded;
                  done_q <= 1'b1;
                  state_q <= versat_pkg::ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (take_start) begin
         cfg_q <= cfg_i;
         acc_q <= '0;
      end else if (state_q == versat_pkg::ST_READ && rsp_i.ready) begin
         acc_q <= folded;
      end
   end

   assign req_o.valid = (state_q == versat_pkg::ST_READ);
   assign req_o.addr = cfg_q.addr;
   assign req_o.len = cfg_q.len;

   assign busy_o = (state_q == versat_pkg::ST_READ);
   assign done_o = done_q;
   assign result_o = result_q;

   // the merge must never route a beat to an idle unit
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      state_q == versat_pkg::ST_IDLE |-> !rsp_i.ready);

   // request held unchanged until the last beat
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_o.valid && !last_beat |=> req_o.valid && $stable(req_o));

endmodule

//--- verilog/xmerge.sv
`timescale 1ns/10ps

module xmerge #(
   parameter int N_SLAVES = 2
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  versat_pkg::db_req_t [N_SLAVES-1:0] s_req_i,
   output versat_pkg::db_rsp_t [N_SLAVES-1:0] s_rsp_o,
   output versat_pkg::db_req_t m_req_o,
   input  versat_pkg::db_rsp_t m_rsp_i
);

   localparam int PTR_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic [N_SLAVES-1:0] grant_q;
   logic [PTR_W-1:0] ptr_q;
   logic [PTR_W-1:0] pick_idx;
   logic pick_valid;
   versat_pkg::db_req_t m_req;

   // next requester after the last served one, wrapping around
   always_comb begin
      int unsigned idx;
      pick_valid = 1'b0;
      pick_idx = ptr_q;
      for (int k = 1; k <= N_SLAVES; k++) begin
         idx = (int'(ptr_q) + k) % N_SLAVES;
         if (!pick_valid && s_req_i[idx].valid) begin
            pick_valid = 1'b1;
            pick_idx = PTR_W'(idx);
         end
      end
   end

   // grant held for a whole burst, then one cycle with no grant
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         grant_q <= '0;
         ptr_q <= PTR_W'(N_SLAVES - 1);
      end else if (grant_q == '0) begin
         if (pick_valid) begin
            grant_q <= N_SLAVES'(1) << pick_idx;
            ptr_q <= pick_idx;
         end
      end else if (m_rsp_i.ready && m_rsp_i.last) begin
         grant_q <= '0;
      end
   end

   // forward the granted request
   always_comb begin
      m_req = '0;
      for (int i = 0; i < N_SLAVES; i++) begin
         if (grant_q[i]) begin
            m_req = s_req_i[i];
         end
      end
   end

   assign m_req_o = m_req;

   // beats only reach the granted slave, data is shared
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_rsp_o[i].ready = m_rsp_i.ready && grant_q[i];
         s_rsp_o[i].last = m_rsp_i.last && grant_q[i];
         s_rsp_o[i].rdata = m_rsp_i.rdata;
      end
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(grant_q));

   // memory request stays up until its last beat
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_req_o.valid && !(m_rsp_i.ready && m_rsp_i.last) |=> m_req_o.valid);

endmodule

//--- verilog/iob_versat.sv
`timescale 1ns/10ps

module iob_versat #(
   parameter int N_UNITS = 2,
   parameter int ADDR_W = 26
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [versat_pkg::DATA_W-1:0] iob_wdata_i,
   input  logic [3:0] iob_wstrb_i,
   output logic iob_rvalid_o,
   output logic [versat_pkg::DATA_W-1:0] iob_rdata_o,
   output versat_pkg::db_req_t m_req_o,
   input  versat_pkg::db_rsp_t m_rsp_i
);

   // lanes between the register block, the units and the merge
   versat_pkg::unit_cfg_t [N_UNITS-1:0] unit_cfg;
   logic [N_UNITS-1:0] unit_start;
   logic [N_UNITS-1:0] unit_busy;
   logic [N_UNITS-1:0] unit_done;
   logic [N_UNITS-1:0][versat_pkg::DATA_W-1:0] unit_result;
   versat_pkg::db_req_t [N_UNITS-1:0] unit_req;
   versat_pkg::db_rsp_t [N_UNITS-1:0] unit_rsp;

   versat_csr #(
      .N_UNITS(N_UNITS),
      .ADDR_W (ADDR_W)
   ) u_csr (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .iob_avalid_i(iob_avalid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .cfg_o       (unit_cfg),
      .start_o     (unit_start),
      .busy_i      (unit_busy),
      .done_i      (unit_done),
      .result_i    (unit_result)
   );

   // one reduction unit per lane
   for (genvar g = 0; g < N_UNITS; g++) begin : g_unit
      versat_vunit u_vunit (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .cfg_i   (unit_cfg[g]),
         .start_i (unit_start[g]),
         .req_o   (unit_req[g]),
         .rsp_i   (unit_rsp[g]),
         .busy_o  (unit_busy[g]),
         .done_o  (unit_done[g]),
         .result_o(unit_result[g])
      );
   end

   xmerge #(
      .N_SLAVES(N_UNITS)
   ) u_merge (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .s_req_i(unit_req),
      .s_rsp_o(unit_rsp),
      .m_req_o(m_req_o),
      .m_rsp_i(m_rsp_i)
   );

endmodule

//--- verification/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model (
   input  logic clk_i,
   input  logic rst_n_i,
   input  versat_pkg::db_req_t req_i,
   output versat_pkg::db_rsp_t rsp_o,
   output int unsigned req_count_o,
   output logic error_o
);

   logic [31:0] base;
   logic [7:0] len;
   logic [31:0] beat_addr;

   // word contents from the full byte address
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      logic [31:0] x;
      x = (addr ^ 32'h3c6ef372) * 32'h9e3779b1;
      mem_word = x ^ (x >> 15) ^ {addr[15:0], addr[31:16]};
   endfunction

   task automatic flag_error(input string msg);
      $display("[FAIL] %0t ns: memory model, %s", $time, msg);
      error_o = 1'b1;
   endtask

   // one request at a time, held until its last beat
   task automatic check_held();
      assert (req_i.valid && req_i.addr == base && req_i.len == len)
         else flag_error("request dropped or changed during a burst");
   endtask

   initial begin
      rsp_o = '0;
      req_count_o = 0;
      error_o = 1'b0;
      forever begin
         @(posedge clk_i);
         if (rst_n_i && req_i.valid) begin
            base = req_i.addr;
            len = req_i.len;
            req_count_o++;
            assert (len != 8'd0) else flag_error("request with zero length");
            // beats step by whole words from an aligned base
            assert (base[1:0] == 2'b00)
               else flag_error("request address not word aligned");
            for (int b = 0; b < int'(len); b++) begin
               beat_addr = base + 32'(4 * b);
               // 0 to 3 idle cycles before each beat
               repeat ($urandom_range(3, 0)) begin
                  #2;
                  rsp_o = '0;
                  @(posedge clk_i);
                  check_held();
               end
               #2;
               rsp_o.ready = 1'b1;
               rsp_o.last = (b == int'(len) - 1);
               rsp_o.rdata = mem_word(beat_addr);
               @(posedge clk_i);
               check_held();
            end
            #2;
            rsp_o = '0;
         end
      end
   end

endmodule

//--- verification/tb_iob_versat.sv
`timescale 1ns/10ps

module tb_iob_versat;

   localparam int N_UNITS = 2;
   localparam int ADDR_W = 26;
   localparam int R_CTRL = 3;
   localparam int R_RESULT = 4;
   localparam int WD_MARGIN = 3000;

   logic clk;
   logic rst_n;
   logic iob_avalid;
   logic [ADDR_W-1:0] iob_addr;
   logic [31:0] iob_wdata;
   logic [3:0] iob_wstrb;
   logic iob_rvalid;
   logic [31:0] iob_rdata;
   versat_pkg::db_req_t m_req;
   versat_pkg::db_rsp_t m_rsp;
   logic mem_error;
   int unsigned mem_req_count;
   int unsigned words_issued;
   int unsigned starts_issued;
   int unsigned cycles;
   // config as written, and as latched by the last accepted start
   versat_pkg::unit_cfg_t shadow_cfg [N_UNITS];
   versat_pkg::unit_cfg_t run_cfg [N_UNITS];

   iob_versat #(
      .N_UNITS(N_UNITS),
      .ADDR_W (ADDR_W)
   ) u_iob_versat (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .iob_avalid_i(iob_avalid),
      .iob_addr_i  (iob_addr),
      .iob_wdata_i (iob_wdata),
      .iob_wstrb_i (iob_wstrb),
      .iob_rvalid_o(iob_rvalid),
      .iob_rdata_o (iob_rdata),
      .m_req_o     (m_req),
      .m_rsp_i     (m_rsp)
   );

   tb_mem_model u_mem (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .req_i      (m_req),
      .rsp_o      (m_rsp),
      .req_count_o(mem_req_count),
      .error_o    (mem_error)
   );

   always #10 clk = ~clk;

   // same address mixing as the memory model
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      logic [31:0] x;
      x = (addr ^ 32'h3c6ef372) * 32'h9e3779b1;
      mem_word = x ^ (x >> 15) ^ {addr[15:0], addr[31:16]};
   endfunction

   function automatic logic [31:0] ref_result(input versat_pkg::unit_cfg_t cfg);
      logic [31:0] acc;
      logic [31:0] w;
      acc = '0;
      for (int i = 0; i < int'(cfg.len); i++) begin
         w = mem_word(cfg.addr + 32'(4 * i));
         case (cfg.op)
            versat_pkg::OP_XOR: acc = acc ^ w;
            versat_pkg::OP_MAX: acc = (w > acc) ? w : acc;
            default: acc = acc + w;
         endcase
      end
      ref_result = acc;
   endfunction

   task automatic fail_check(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   // one IOb access, ends 2 ns after the edge that took it
   task automatic bus_access(input int unsigned word, input logic wr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      iob_avalid = 1'b1;
      iob_addr = ADDR_W'(word * 4);
      iob_wdata = wdata;
      iob_wstrb = wr ? 4'($urandom_range(15, 1)) : 4'h0;
      @(posedge clk);
      #2;
      iob_avalid = 1'b0;
      iob_wstrb = 4'h0;
      rdata = iob_rdata;
      assert (iob_rvalid == !wr)
         else fail_check($sformatf("rvalid %b after access to word %0d", iob_rvalid, word));
   endtask

   task automatic reg_write(input int unsigned word, input logic [31:0] data);
      logic [31:0] unused;
      bus_access(word, 1'b1, data, unused);
   endtask

   task automatic expect_read(input int unsigned word, input logic [31:0] exp);
      logic [31:0] got;
      bus_access(word, 1'b0, $urandom, got);
      assert (got == exp)
         else fail_check($sformatf("word %0d read %h, expected %h", word, got, exp));
   endtask

   // upper bits of LEN and OP carry noise the registers drop
   task automatic configure(input int u, input logic [31:0] addr, input int len, input int op);
      reg_write(8 * u, addr);
      reg_write(8 * u + 1, {24'($urandom), 8'(len)});
      reg_write(8 * u + 2, {30'($urandom), 2'(op)});
      shadow_cfg[u].addr = addr;
      shadow_cfg[u].len = 8'(len);
      shadow_cfg[u].op = versat_pkg::opcode_e'(2'(op));
   endtask

   task automatic start_unit(input int u);
      reg_write(8 * u + R_CTRL, 32'h1);
      run_cfg[u] = shadow_cfg[u];
      words_issued += shadow_cfg[u].len;
      starts_issued++;
   endtask

   // spare cycle first, so the poll never sees the previous run
   task automatic finish_unit(input int u);
      logic [31:0] ctrl;
      @(posedge clk);
      #2;
      ctrl = '0;
      while (!ctrl[1]) begin
         bus_access(8 * u + R_CTRL, 1'b0, '0, ctrl);
      end
      assert (!ctrl[0]) else fail_check($sformatf("unit %0d busy with done set", u));
      expect_read(8 * u + R_RESULT, ref_result(run_cfg[u]));
   endtask

   // budget grows with the burst words and starts issued so far
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > 200 * words_issued + 50 * starts_issued + WD_MARGIN) begin
         $display("watchdog expired after %0d cycles, the DUT stopped making progress", cycles);
         $display("tests failed");
         $fatal(1, "run aborted by the watchdog");
      end
   end

   always @(posedge mem_error) begin
      $display("tests failed");
      $fatal(1, "memory model check failed");
   end

   initial begin
      int unsigned base;
      int first;
      void'($urandom(32'h91e4cd9e));
      clk = 1'b0;
      rst_n = 1'b0;
      iob_avalid = 1'b0;
      iob_addr = '0;
      iob_wdata = '0;
      iob_wstrb = 4'h0;
      words_issued = 0;
      starts_issued = 0;
      cycles = 0;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // readback, every register zero after reset
      for (int u = 0; u < N_UNITS; u++) begin
         for (int r = 0; r <= R_RESULT; r++) begin
            expect_read(8 * u + r, '0);
         end
         configure(u, $urandom, $urandom_range(255, 0), $urandom_range(3, 0));
         expect_read(8 * u, shadow_cfg[u].addr);
         expect_read(8 * u + 1, 32'(shadow_cfg[u].len));
         expect_read(8 * u + 2, 32'(shadow_cfg[u].op));
      end
      // holes inside the windows and words past the last unit
      for (int k = 0; k < 3; k++) begin
         expect_read(8 * $urandom_range(N_UNITS - 1, 0) + 5 + k, '0);
         expect_read(8 * N_UNITS + $urandom_range(1 << 20, 0), '0);
      end

      // each unit alone with every opcode, code 3 included
      for (int u = 0; u < N_UNITS; u++) begin
         for (int op = 0; op < 4; op++) begin
            configure(u, $urandom & ~32'h3, $urandom_range(40, 1), op);
            start_unit(u);
            finish_unit(u);
         end
      end

      // both units started back to back
      base = mem_req_count;
      configure(0, $urandom & ~32'h3, $urandom_range(40, 1), 0);
      configure(1, $urandom & ~32'h3, $urandom_range(40, 1), 2);
      start_unit(0);
      start_unit(1);
      finish_unit(0);
      finish_unit(1);
      assert (mem_req_count == base + 2)
         else fail_check($sformatf("memory saw %0d requests, expected 2", mem_req_count - base));

      // empty bursts never reach the memory
      for (int u = 0; u < N_UNITS; u++) begin
         base = mem_req_count;
         configure(u, $urandom & ~32'h3, 0, $urandom_range(3, 0));
         start_unit(u);
         finish_unit(u);
         assert (mem_req_count == base) else fail_check("zero-length start reached the memory");
      end

      // a start while busy is dropped, the run keeps its first configuration
      configure(0, $urandom & ~32'h3, $urandom_range(40, 20), 1);
      start_unit(0);
      @(posedge clk);
      #2;
      expect_read(R_CTRL, 32'h1);
      configure(0, $urandom & ~32'h3, $urandom_range(40, 1), 2);
      reg_write(R_CTRL, 32'h1);
      finish_unit(0);
      start_unit(0);
      @(posedge clk);
      #2;
      expect_read(R_CTRL, 32'h1);
      finish_unit(0);

      // soak, 60 configurations in random start order
      for (int n = 0; n < 30; n++) begin
         for (int u = 0; u < N_UNITS; u++) begin
            configure(u, $urandom & ~32'h3, $urandom_range(40, 0), $urandom_range(3, 0));
         end
         first = $urandom_range(1, 0);
         start_unit(first);
         repeat ($urandom_range(3, 0)) begin
            @(posedge clk);
            #2;
         end
         start_unit(1 - first);
         finish_unit(0);
         finish_unit(1);
      end

      if (!mem_error) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("tests failed");
         $fatal(1, "memory model reported an error");
      end
   end

endmodule

//--- list.f
verilog/versat_pkg.sv
verilog/versat_csr.sv
verilog/versat_vunit.sv
verilog/xmerge.sv
verilog/iob_versat.sv
verification/tb_mem_model.sv
verification/tb_iob_versat.sv
